/* logic/adc_pkg.sv */
// ********************
// ADC sample format shared by the fan-out, the monitors and the collector
// ********************

`default_nettype none

package adc_pkg;

  // ********************
  // Link geometry
  // ********************

  // Channels carried in one ADC word
  localparam int num_channels = 4;

  // Offset-binary sample width per channel
  localparam int sample_width = 16;

  // Full ADC bus, channel 0 in the low bits
  localparam int adc_data_width = num_channels * sample_width;

  // One channel's sample as it leaves the fan-out
  typedef struct packed {
    logic                    valid;
    logic [sample_width-1:0] data;
  } adc_sample_t;

endpackage : adc_pkg

`default_nettype wire

/* logic/pn_pkg.sv */
// ********************
// PN sequence definitions and next-word functions for the link checker
// ********************

`default_nettype none

package pn_pkg;

  // Sequence select, one per channel
  typedef enum logic {
    pn_seq_pn9,
    pn_seq_pn23
  } pn_seq_t;

  // Two samples packed per comparison word
  localparam int pn_word_width = 32;

  // Run length to enter or leave sync
  localparam int pn_sync_count = 16;

  // Run counter only needs to reach pn_sync_count - 1
  localparam int pn_run_width = $clog2(pn_sync_count);

  // Per-channel error counter width
  localparam int err_count_width = 8;

  // ********************
  // Sequence generators
  // ********************

  // Advance a Fibonacci LFSR by one full word
  // Bit 0 of the word is the newest bit, bit 31 the oldest
  function automatic logic [pn_word_width-1:0] pn_step(
    input logic [pn_word_width-1:0] word,
    input int                       tap_a,
    input int                       tap_b
  );
    logic [pn_word_width-1:0] state;
    state = word;
    for (int i = 0; i < pn_word_width; i++) begin
      // New bit from the two taps, counted back from the newest bit
      state = {state[pn_word_width-2:0], state[tap_a] ^ state[tap_b]};
    end
    return state;
  endfunction

  // PN9, x^9 + x^5 + 1
  function automatic logic [pn_word_width-1:0] pn9_next(
    input logic [pn_word_width-1:0] word
  );
    return pn_step(word, 8, 4);
  endfunction

  // PN23, x^23 + x^18 + 1
  function automatic logic [pn_word_width-1:0] pn23_next(
    input logic [pn_word_width-1:0] word
  );
    return pn_step(word, 22, 17);
  endfunction

endpackage : pn_pkg

`default_nettype wire

/* logic/adc_sample_fanout.sv */
// ********************
// ADC word register that splits the wide bus into per-channel samples
// ********************

`timescale 1ns/1ps
`default_nettype none

module adc_sample_fanout (
  input  logic                                            adc_clk,
  input  logic                                            reset,
  input  logic                                            adc_valid,
  input  logic [adc_pkg::adc_data_width-1:0]              adc_data,
  output adc_pkg::adc_sample_t [adc_pkg::num_channels-1:0] samples
);

  import adc_pkg::*;

  // Registered copy of the bus
  logic                      valid_q;
  logic [adc_data_width-1:0] data_q;

  // Valid follows the ADC strobe one cycle late
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= adc_valid;
    end
  end

  // Data only moves with a valid word
  always_ff @(posedge adc_clk) begin
    if (adc_valid) begin
      data_q <= adc_data;
    end
  end

  // ********************
  // Channel split
  // ********************

  // Every channel sees the same valid and its own slice of the word
  always_comb begin
    for (int ch = 0; ch < num_channels; ch++) begin
      samples[ch].valid = valid_q;
      samples[ch].data  = data_q[ch*sample_width +: sample_width];
    end
  end

endmodule : adc_sample_fanout

`default_nettype wire

/* logic/pn_sync_tracker.sv */
// ********************
// PN word compare with sync hysteresis and per-word error pulse
// ********************

`timescale 1ns/1ps
`default_nettype none

module pn_sync_tracker (
  input  logic                             adc_clk,
  input  logic                             reset,
  input  logic                             word_valid,
  input  logic [pn_pkg::pn_word_width-1:0] rx_word,
  input  logic [pn_pkg::pn_word_width-1:0] exp_word,
  output logic                             oos,
  output logic                             err
);

  import pn_pkg::*;

  logic                    match;
  logic                    run_hit;
  logic                    run_done;
  logic [pn_run_width-1:0] run_count;

  // All-zero word never matches, a dead link stays out of sync
  assign match = (rx_word == exp_word) && (rx_word != '0);

  // Word pushes toward the other state
  // Out of sync wants matches, in sync watches for mismatches
  assign run_hit = (oos == match);

  // Last word of a full run
  assign run_done = (run_count == pn_run_width'(pn_sync_count - 1));

  // ********************
  // Hysteresis
  // ********************

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      oos       <= 1'b1;
      err       <= 1'b0;
      run_count <= '0;
    end else begin
      // Error only counts while locked, one pulse per bad word
      err <= word_valid & ~oos & ~match;

      if (word_valid) begin
        if (run_hit) begin
          if (run_done) begin
            // Run complete, flip state and start over
            oos       <= ~oos;
            run_count <= '0;
          end else begin
            run_count <= run_count + 1'b1;
          end
        end else begin
          // Run broken
          run_count <= '0;
        end
      end
    end
  end

endmodule : pn_sync_tracker

`default_nettype wire

/* logic/channel_pn_monitor.sv */
// ********************
// Per-channel PN monitor, pairs samples into words and predicts the next
// ********************

`timescale 1ns/1ps
`default_nettype none

module channel_pn_monitor (
  input  logic                 adc_clk,
  input  logic                 reset,
  input  adc_pkg::adc_sample_t sample,
  input  pn_pkg::pn_seq_t      pn_sel,
  output logic                 pn_oos,
  output logic                 pn_err
);

  import adc_pkg::*;
  import pn_pkg::*;

  // Two's complement view of the sample
  logic [sample_width-1:0]  conv_data;

  // High when the next sample closes a pair
  logic                     pair_phase;
  logic                     word_valid;

  logic [pn_word_width-1:0] rx_word;
  logic [pn_word_width-1:0] exp_word;
  logic [pn_word_width-1:0] seed_word;

  // Offset binary to two's complement, flip the sign bit
  assign conv_data = {~sample.data[sample_width-1], sample.data[sample_width-2:0]};

  // Reseed from the data until locked, then free-run on the prediction
  assign seed_word = pn_oos ? rx_word : exp_word;

  // ********************
  // Sample pairing
  // ********************

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      pair_phase <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      // Strobe lands one cycle after the second sample
      word_valid <= sample.valid & pair_phase;
      if (sample.valid) begin
        pair_phase <= ~pair_phase;
      end
    end
  end

  // First sample ends up in the upper half
  always_ff @(posedge adc_clk) begin
    if (sample.valid) begin
      rx_word <= {rx_word[pn_word_width-sample_width-1:0], conv_data};
    end
  end

  // ********************
  // Prediction
  // ********************

  // Updated on the strobe, the tracker still sees the old prediction
  always_ff @(posedge adc_clk) begin
    if (word_valid) begin
      case (pn_sel)
        pn_seq_pn9:  exp_word <= pn9_next(seed_word);
        pn_seq_pn23: exp_word <= pn23_next(seed_word);
        default:     exp_word <= pn23_next(seed_word);
      endcase
    end
  end

  pn_sync_tracker u_pn_sync_tracker (
    .adc_clk    (adc_clk),
    .reset      (reset),
    .word_valid (word_valid),
    .rx_word    (rx_word),
    .exp_word   (exp_word),
    .oos        (pn_oos),
    .err        (pn_err)
  );

endmodule : channel_pn_monitor

`default_nettype wire

/* logic/pn_status_collector.sv */
// ********************
// Status collector, summary out-of-sync and saturating error counters
// ********************

`timescale 1ns/1ps
`default_nettype none

module pn_status_collector (
  input  logic                                adc_clk,
  input  logic                                reset,
  input  logic [adc_pkg::num_channels-1:0]    pn_oos,
  input  logic [adc_pkg::num_channels-1:0]    pn_err,
  input  logic                                err_clear,
  output logic [adc_pkg::num_channels-1:0][pn_pkg::err_count_width-1:0] err_count,
  output logic                                any_oos
);

  import adc_pkg::*;
  import pn_pkg::*;

  // All ones marks a saturated counter
  localparam logic [err_count_width-1:0] count_max = '1;

  // ********************
  // Error counters
  // ********************

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      err_count <= '0;
    end else begin
      for (int ch = 0; ch < num_channels; ch++) begin
        // Clear wins over an error in the same cycle
        if (err_clear) begin
          err_count[ch] <= '0;
        end else if (pn_err[ch] && (err_count[ch] != count_max)) begin
          err_count[ch] <= err_count[ch] + 1'b1;
        end
      end
    end
  end

  // Any channel not locked, starts high like the trackers
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      any_oos <= 1'b1;
    end else begin
      any_oos <= |pn_oos;
    end
  end

endmodule : pn_status_collector

`default_nettype wire

/* logic/adc_pn_check_top.sv */
// ********************
// ADC link checker top, fan-out, channel monitors and status
// ********************

`timescale 1ns/1ps
`default_nettype none

module adc_pn_check_top (
  input  logic                                       adc_clk,
  input  logic                                       reset,
  input  logic                                       adc_valid,
  input  logic [adc_pkg::adc_data_width-1:0]         adc_data,
  input  pn_pkg::pn_seq_t [adc_pkg::num_channels-1:0] pn_sel,
  input  logic                                       err_clear,
  output logic [adc_pkg::num_channels-1:0]           pn_oos,
  output logic [adc_pkg::num_channels-1:0]           pn_err,
  output logic [adc_pkg::num_channels-1:0][pn_pkg::err_count_width-1:0] err_count,
  output logic                                       any_oos
);

  import adc_pkg::*;

  // Per-channel samples out of the fan-out
  adc_sample_t [num_channels-1:0] samples;

  adc_sample_fanout u_adc_sample_fanout (
    .adc_clk   (adc_clk),
    .reset     (reset),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .samples   (samples)
  );

  // One monitor per channel
  for (genvar ch = 0; ch < num_channels; ch++) begin : g_channel
    channel_pn_monitor u_channel_pn_monitor (
      .adc_clk (adc_clk),
      .reset   (reset),
      .sample  (samples[ch]),
      .pn_sel  (pn_sel[ch]),
      .pn_oos  (pn_oos[ch]),
      .pn_err  (pn_err[ch])
    );
  end

  // Error pulses also leave the top directly
  pn_status_collector u_pn_status_collector (
    .adc_clk   (adc_clk),
    .reset     (reset),
    .pn_oos    (pn_oos),
    .pn_err    (pn_err),
    .err_clear (err_clear),
    .err_count (err_count),
    .any_oos   (any_oos)
  );

endmodule : adc_pn_check_top

`default_nettype wire

/* verification/adc_pn_check_tb.sv */
// ********************
// ADC PN link checker testbench with a serial PN model and a sync and error model
// ********************

`timescale 1ns/1ps
`default_nettype none

module adc_pn_check_tb;

  import adc_pkg::*;
  import pn_pkg::*;

  // Words per phase
  localparam int lock_words     = 24;
  localparam int noise_words    = 600;
  localparam int burst_words    = 20;
  localparam int foreign_words  = 60;
  localparam int total_samples  = 2 * (lock_words + noise_words + burst_words + foreign_words);
  // Valid gaps stretch each sample to about 1.3 cycles
  // Margin covers resets and drains
  localparam int timeout_cycles = 4 * total_samples + 200;
  // Pulse lands 3 cycles after the last sample and the counter one cycle later
  localparam int drain_cycles   = 8;
  localparam int count_limit    = (1 << err_count_width) - 1;

  // Channel stimulus modes
  localparam int mode_match = 0;
  localparam int mode_other = 1;
  localparam int mode_zero  = 2;

  logic                                          adc_clk = 1'b0;
  logic                                          reset;
  logic                                          adc_valid;
  logic [adc_data_width-1:0]                     adc_data;
  pn_seq_t [num_channels-1:0]                    pn_sel;
  logic                                          err_clear;
  logic [num_channels-1:0]                       pn_oos;
  logic [num_channels-1:0]                       pn_err;
  logic [num_channels-1:0][err_count_width-1:0]  err_count;
  logic                                          any_oos;

  integer seed = 41239;
  int     cycle_count = 0;

  // Generator state and expected status per channel
  logic [22:0] lfsr         [num_channels];
  pn_seq_t     gen_seq      [num_channels];
  int          mode         [num_channels];
  logic        m_oos        [num_channels];
  int          m_run        [num_channels];
  logic        m_prev_clean [num_channels];
  int          m_errs       [num_channels];
  int          m_count      [num_channels];
  int          err_pulses   [num_channels];

  adc_pn_check_top u_adc_pn_check_top (
    .adc_clk   (adc_clk),
    .reset     (reset),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .pn_sel    (pn_sel),
    .err_clear (err_clear),
    .pn_oos    (pn_oos),
    .pn_err    (pn_err),
    .err_count (err_count),
    .any_oos   (any_oos)
  );

  always #5 adc_clk = ~adc_clk;

  // Error pulses seen on the DUT outputs
  always @(posedge adc_clk) begin
    for (int ch = 0; ch < num_channels; ch++) begin
      if (reset) begin
        err_pulses[ch] <= 0;
      end else if (pn_err[ch]) begin
        err_pulses[ch] <= err_pulses[ch] + 1;
      end
    end
  end

  // Watchdog
  always @(posedge adc_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout after %0d cycles, stimulus never completed", cycle_count);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  // ********************
  // Reference PN source
  // ********************

  // Bit-serial LFSR with the oldest bit in the sample MSB
  function automatic logic [sample_width-1:0] next_sample(input int ch);
    logic [sample_width-1:0] s;
    logic                    nb;
    s = '0;
    for (int i = 0; i < sample_width; i++) begin
      if (gen_seq[ch] == pn_seq_pn9) begin
        nb = lfsr[ch][8] ^ lfsr[ch][4];
      end else begin
        nb = lfsr[ch][22] ^ lfsr[ch][17];
      end
      lfsr[ch] = {lfsr[ch][21:0], nb};
      s = {s[sample_width-2:0], nb};
    end
    return s;
  endfunction

  // Sync rule per received word
  // A clean word is an uncorrupted word of the selected sequence
  task automatic model_word(input int ch, input logic clean);
    logic match;
    // Out of sync the prediction comes from the previous received word
    match = m_oos[ch] ? (clean && m_prev_clean[ch]) : clean;
    if (!m_oos[ch] && !match) begin
      m_errs[ch]++;
      if (m_count[ch] < count_limit) begin
        m_count[ch]++;
      end
    end
    if (m_oos[ch] == match) begin
      if (m_run[ch] == pn_sync_count - 1) begin
        m_oos[ch] = ~m_oos[ch];
        m_run[ch] = 0;
      end else begin
        m_run[ch]++;
      end
    end else begin
      m_run[ch] = 0;
    end
    m_prev_clean[ch] = clean;
  endtask

  // ********************
  // Stimulus
  // ********************

  // Random idle cycles give about 75% valid duty
  task automatic drive_sample(input logic [adc_data_width-1:0] data);
    @(posedge adc_clk);
    while (($random(seed) & 3) == 0) begin
      adc_valid <= 1'b0;
      @(posedge adc_clk);
    end
    adc_valid <= 1'b1;
    adc_data  <= data;
  endtask

  // One word per channel
  // A corrupt flag flips one bit in the upper sample
  task automatic send_word(input logic [num_channels-1:0] corrupt);
    logic [adc_data_width-1:0] hi;
    logic [adc_data_width-1:0] lo;
    logic [sample_width-1:0]   s_hi;
    logic [sample_width-1:0]   s_lo;
    for (int ch = 0; ch < num_channels; ch++) begin
      if (mode[ch] == mode_zero) begin
        s_hi = '0;
        s_lo = '0;
      end else begin
        s_hi = next_sample(ch);
        s_lo = next_sample(ch);
      end
      if (corrupt[ch]) begin
        s_hi = s_hi ^ (16'h1 << ($random(seed) & 15));
      end
      // Two's complement to offset binary
      hi[ch*sample_width +: sample_width] = s_hi ^ (16'h1 << (sample_width - 1));
      lo[ch*sample_width +: sample_width] = s_lo ^ (16'h1 << (sample_width - 1));
    end
    drive_sample(hi);
    drive_sample(lo);
    for (int ch = 0; ch < num_channels; ch++) begin
      model_word(ch, (mode[ch] == mode_match) && !corrupt[ch]);
    end
  endtask

  task automatic drain();
    @(posedge adc_clk);
    adc_valid <= 1'b0;
    repeat (drain_cycles) @(posedge adc_clk);
  endtask

  task automatic apply_reset();
    reset     <= 1'b1;
    adc_valid <= 1'b0;
    err_clear <= 1'b0;
    repeat (5) @(posedge adc_clk);
    reset <= 1'b0;
    for (int ch = 0; ch < num_channels; ch++) begin
      m_oos[ch]        = 1'b1;
      m_run[ch]        = 0;
      m_prev_clean[ch] = 1'b0;
      m_errs[ch]       = 0;
      m_count[ch]      = 0;
    end
  endtask

  // Random sequence per channel
  // Foreign mode puts the last two channels on a wrong or dead stream
  task automatic setup_channels(input logic foreign);
    pn_seq_t sel;
    for (int ch = 0; ch < num_channels; ch++) begin
      sel         = pn_seq_t'($random(seed) & 1);
      pn_sel[ch] <= sel;
      gen_seq[ch] = sel;
      mode[ch]    = mode_match;
      lfsr[ch]    = 23'($random(seed)) | 23'd1;
    end
    if (foreign) begin
      mode[num_channels-2]    = mode_other;
      gen_seq[num_channels-2] = (gen_seq[num_channels-2] == pn_seq_pn9) ? pn_seq_pn23
                                                                         : pn_seq_pn9;
      mode[num_channels-1]    = mode_zero;
    end
  endtask

  task automatic pulse_clear();
    @(posedge adc_clk);
    err_clear <= 1'b1;
    @(posedge adc_clk);
    err_clear <= 1'b0;
    repeat (2) @(posedge adc_clk);
    for (int ch = 0; ch < num_channels; ch++) begin
      m_count[ch] = 0;
    end
  endtask

  task automatic check_status();
    logic exp_any;
    exp_any = 1'b0;
    for (int ch = 0; ch < num_channels; ch++) begin
      check_value($sformatf("pn_oos[%0d]", ch), pn_oos[ch], m_oos[ch]);
      check_value($sformatf("err_count[%0d]", ch), err_count[ch], m_count[ch]);
      check_value($sformatf("pn_err pulses[%0d]", ch), err_pulses[ch], m_errs[ch]);
      exp_any = exp_any | m_oos[ch];
    end
    check_value("any_oos", any_oos, exp_any);
  endtask

  // ********************
  // Test sequence
  // ********************

  initial begin
    logic [num_channels-1:0] corrupt;
    reset     = 1'b1;
    adc_valid = 1'b0;
    adc_data  = '0;
    err_clear = 1'b0;
    for (int ch = 0; ch < num_channels; ch++) begin
      pn_sel[ch] = pn_seq_pn9;
    end

    apply_reset();
    check_status();

    // One word short of a full run keeps every channel out of sync
    setup_channels(1'b0);
    repeat (pn_sync_count) send_word('0);
    drain();
    check_status();
    // The next word completes the run and every channel locks
    send_word('0);
    drain();
    check_status();
    repeat (lock_words - pn_sync_count - 1) send_word('0);
    drain();
    check_status();

    // Isolated hits with channel 0 hit on every other word to saturate its counter
    for (int i = 0; i < noise_words; i++) begin
      corrupt    = '0;
      corrupt[0] = (i % 2 == 0);
      for (int ch = 1; ch < num_channels; ch++) begin
        corrupt[ch] = (($random(seed) & 7) == 0);
      end
      send_word(corrupt);
    end
    drain();
    check_status();

    // Long burst knocks channel 0 out of sync
    repeat (burst_words) send_word(num_channels'(1));
    drain();
    check_status();
    pulse_clear();
    check_status();

    // Wrong sequence and dead link never lock
    apply_reset();
    setup_channels(1'b1);
    repeat (foreign_words) send_word('0);
    drain();
    check_status();

    $display("=== PASS ===");
    $finish;
  end

endmodule : adc_pn_check_tb

`default_nettype wire

/* vlog.f */
logic/adc_pkg.sv
logic/pn_pkg.sv
logic/adc_sample_fanout.sv
logic/pn_sync_tracker.sv
logic/channel_pn_monitor.sv
logic/pn_status_collector.sv
logic/adc_pn_check_top.sv
verification/adc_pn_check_tb.sv

/* Bender.yml */
package:
  name: adc_pn_check

sources:
  # Packages first, then the blocks bottom up
  - files:
      - logic/adc_pkg.sv
      - logic/pn_pkg.sv
      - logic/adc_sample_fanout.sv
      - logic/pn_sync_tracker.sv
      - logic/channel_pn_monitor.sv
      - logic/pn_status_collector.sv
      - logic/adc_pn_check_top.sv
  - target: test
    files:
      - verification/adc_pn_check_tb.sv
